// ==== Makefile ====
VERILATOR ?= verilator
TOP := sl28_cpld_tb
FILELIST := sl28_cpld.f
VFLAGS := --binary --timing --timescale 1ns/1ps
OBJDIR := obj_dir

BIN := $(OBJDIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJDIR)

// ==== dv/sl28_cpld_tb.sv ====
// testbench for the bmc register side; drives wishbone cycles and pins, checks reads against a model.
`timescale 1ns/1ps
`include "sl28_defines.svh"

module sl28_cpld_tb;
	import sl28_pkg::*;

	localparam int clk_period = 8;
	localparam int max_xfers = 400;
	localparam int xfer_cycles = 20;

	logic clk;
	logic rst;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [`SL28_NUM_GPIO-1:0] gpio_in;
	logic [`SL28_NUM_GPIO-1:0] gpio_out;
	logic [`SL28_NUM_GPIO-1:0] gpio_oe;
	logic [`SL28_NUM_EVT-1:0] evt_pins; // smb_alert_n, rtc_int_n, sleep_n, pwr_btn_n.
	logic irq;

	// shadow registers.
	logic [`SL28_DATA_W-1:0] dir_m;
	logic [`SL28_DATA_W-1:0] out_m;
	logic [`SL28_DATA_W-1:0] gie_m;
	logic [`SL28_DATA_W-1:0] gip_m;
	logic [`SL28_NUM_IRQ-1:0] intc_ie_m;
	logic [`SL28_NUM_EVT-1:0] intc_ip_m;
	logic [31:0] rng_state = 32'd90;
	logic [`SL28_DATA_W-1:0] exp_q[$];
	logic [`SL28_ADDR_W-1:0] adr_q[$];

	sl28_cpld_top sl28_cpld_top_i (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.pwr_btn_n(evt_pins[0]),
		.sleep_n(evt_pins[1]),
		.rtc_int_n(evt_pins[2]),
		.smb_alert_n(evt_pins[3]),
		.irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(max_xfers * xfer_cycles * clk_period);
		$display("watchdog expired, the test did not finish in time");
		$display("Regression failed");
		$fatal(1, "timeout");
	end

	function automatic logic [7:0] rand_byte();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state[7:0];
	endfunction

	function automatic logic is_mapped(input logic [`SL28_ADDR_W-1:0] adr);
		return adr inside {`SL28_ADDR_VERSION, `SL28_ADDR_GPIO_DIR, `SL28_ADDR_GPIO_OUT,
			`SL28_ADDR_GPIO_IN, `SL28_ADDR_GPIO_IE, `SL28_ADDR_GPIO_IP, `SL28_ADDR_GPI,
			`SL28_ADDR_INTC_IE, `SL28_ADDR_INTC_IP};
	endfunction

	function automatic logic ref_irq();
		return |({|(gip_m & gie_m), intc_ip_m} & intc_ie_m); // gpio level on bit 4.
	endfunction

	function automatic logic [7:0] ref_read(input logic [`SL28_ADDR_W-1:0] adr);
		case (adr)
			`SL28_ADDR_VERSION: return `SL28_CPLD_VERSION;
			`SL28_ADDR_GPIO_DIR: return dir_m;
			`SL28_ADDR_GPIO_OUT: return out_m;
			`SL28_ADDR_GPIO_IN: return gpio_in;
			`SL28_ADDR_GPIO_IE: return gie_m;
			`SL28_ADDR_GPIO_IP: return gip_m;
			`SL28_ADDR_GPI: return {4'b0, evt_pins};
			`SL28_ADDR_INTC_IE: return {3'b0, intc_ie_m};
			`SL28_ADDR_INTC_IP: return {3'b0, |(gip_m & gie_m), intc_ip_m};
			default: return 8'h00;
		endcase
	endfunction

	// write one clears pending bits.
	function automatic void apply_write(input logic [4:0] adr, input logic [7:0] dat);
		case (adr)
			`SL28_ADDR_GPIO_DIR: dir_m = dat;
			`SL28_ADDR_GPIO_OUT: out_m = dat;
			`SL28_ADDR_GPIO_IE: gie_m = dat;
			`SL28_ADDR_GPIO_IP: gip_m = gip_m & ~dat;
			`SL28_ADDR_INTC_IE: intc_ie_m = dat[4:0];
			`SL28_ADDR_INTC_IP: intc_ip_m = intc_ip_m & ~dat[3:0];
			default: begin
			end
		endcase
	endfunction

	task automatic expect_eq(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic wb_xfer(input logic we, input logic [4:0] adr, input logic [7:0] dat);
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		do begin
			@(posedge clk);
		end while (!wb_rsp.ack);
		wb_req <= '0; // stb drops the cycle after ack.
		if (we) begin
			apply_write(adr, dat);
		end
	endtask

	task automatic wb_write(input logic [4:0] adr, input logic [7:0] dat);
		wb_xfer(1'b1, adr, dat);
	endtask

	task automatic wb_read(input logic [4:0] adr);
		exp_q.push_back(ref_read(adr));
		adr_q.push_back(adr);
		wb_xfer(1'b0, adr, 8'h00);
	endtask

	task automatic set_gpio_in(input logic [7:0] v);
		@(posedge clk);
		gip_m = gip_m | (gpio_in ^ v); // any change.
		gpio_in <= v;
		repeat (12) @(posedge clk);
	endtask

	task automatic set_evt_pins(input logic [3:0] v);
		@(posedge clk);
		intc_ip_m[0] = intc_ip_m[0] | (evt_pins[0] ^ v[0]);
		intc_ip_m[3:1] = intc_ip_m[3:1] | (evt_pins[3:1] & ~v[3:1]); // falling only.
		evt_pins <= v;
		repeat (12) @(posedge clk);
	endtask

	task automatic check_irq();
		repeat (3) @(posedge clk);
		expect_eq({7'b0, irq}, {7'b0, ref_irq()}, "irq");
	endtask

	always @(posedge clk) begin
		if (wb_rsp.ack && !wb_req.we) begin
			if (exp_q.size() == 0) begin
				$display("read data came back with no read outstanding at %0t ns", $time);
				$display("Regression failed");
				$fatal(1, "unexpected ack");
			end else begin
				expect_eq(wb_rsp.dat, exp_q.pop_front(),
					$sformatf("read of address %h", adr_q.pop_front()));
			end
		end
	end

	initial begin
		int n;
		logic [7:0] v;
		rst = 1'b1;
		wb_req = '0;
		gpio_in = 8'h5a;
		evt_pins = 4'hf;
		dir_m = '0;
		out_m = '0;
		gie_m = '0;
		gip_m = '0;
		intc_ie_m = '0;
		intc_ip_m = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		expect_eq({7'b0, wb_rsp.ack}, 8'h00, "ack after reset");
		expect_eq({7'b0, irq}, 8'h00, "irq after reset");
		expect_eq(gpio_oe, 8'h00, "gpio_oe after reset");
		wb_read(`SL28_ADDR_GPIO_OUT);
		wb_read(`SL28_ADDR_GPIO_DIR);
		wb_read(`SL28_ADDR_GPIO_IE);
		wb_read(`SL28_ADDR_GPIO_IP);
		wb_read(`SL28_ADDR_INTC_IE);
		wb_read(`SL28_ADDR_INTC_IP);
		wb_read(`SL28_ADDR_VERSION);
		wb_write(`SL28_ADDR_VERSION, rand_byte());
		wb_read(`SL28_ADDR_VERSION);
		for (n = 0; n < 32; n++) begin
			if (!is_mapped(n[4:0])) begin
				wb_read(n[4:0]);
				wb_write(n[4:0], rand_byte());
				wb_read(n[4:0]);
			end
		end
		repeat (8) begin
			wb_write(`SL28_ADDR_GPIO_DIR, rand_byte());
			wb_write(`SL28_ADDR_GPIO_OUT, rand_byte());
			wb_read(`SL28_ADDR_GPIO_DIR);
			wb_read(`SL28_ADDR_GPIO_OUT);
			expect_eq(gpio_oe, dir_m, "gpio_oe");
			expect_eq(gpio_out, out_m, "gpio_out");
			set_gpio_in(rand_byte());
			wb_read(`SL28_ADDR_GPIO_IN);
		end
		wb_read(`SL28_ADDR_GPIO_IP);
		wb_write(`SL28_ADDR_GPIO_IP, 8'hff);
		wb_read(`SL28_ADDR_GPIO_IP);
		repeat (4) begin
			v = rand_byte();
			v = 8'h01 << v[2:0]; // one pin per round.
			set_gpio_in(gpio_in ^ v);
			wb_read(`SL28_ADDR_GPIO_IP);
			check_irq();
			wb_write(`SL28_ADDR_INTC_IE, 8'h10); // gpio source still masked in the bank.
			check_irq();
			wb_read(`SL28_ADDR_INTC_IP);
			wb_write(`SL28_ADDR_INTC_IE, 8'h00);
			wb_write(`SL28_ADDR_GPIO_IE, v);
			check_irq();
			wb_read(`SL28_ADDR_INTC_IP);
			wb_write(`SL28_ADDR_INTC_IE, 8'h10);
			check_irq();
			wb_write(`SL28_ADDR_GPIO_IP, v);
			check_irq();
			wb_read(`SL28_ADDR_GPIO_IP);
			wb_write(`SL28_ADDR_INTC_IE, 8'h00);
			wb_write(`SL28_ADDR_GPIO_IE, 8'h00);
		end
		for (n = 0; n < 4; n++) begin
			set_evt_pins(evt_pins & ~(4'b0001 << n));
			wb_read(`SL28_ADDR_GPI);
			wb_read(`SL28_ADDR_INTC_IP);
			set_evt_pins(4'hf);
			wb_read(`SL28_ADDR_GPI);
			wb_read(`SL28_ADDR_INTC_IP);
			check_irq();
		end
		wb_write(`SL28_ADDR_INTC_IE, 8'h0f);
		check_irq();
		wb_write(`SL28_ADDR_INTC_IP, 8'h0f);
		check_irq();
		wb_read(`SL28_ADDR_INTC_IP);
		repeat (6) begin
			v = rand_byte();
			set_evt_pins(v[3:0]);
			wb_read(`SL28_ADDR_GPI);
			wb_read(`SL28_ADDR_INTC_IP);
			check_irq();
			wb_write(`SL28_ADDR_INTC_IP, rand_byte());
			check_irq();
			wb_read(`SL28_ADDR_INTC_IP);
		end
		repeat (2) @(posedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== sl28_cpld.f ====
+incdir+verilog
verilog/sl28_pkg.sv
verilog/sl28_wb_csr.sv
verilog/sl28_gpio_bank.sv
verilog/sl28_event_inputs.sv
verilog/sl28_intc.sv
verilog/sl28_cpld_top.sv
dv/sl28_cpld_tb.sv

// ==== verilog/sl28_cpld_top.sv ====
// top level of the bmc register side; connects the wishbone slave to the gpio, event and intc blocks.
`timescale 1ns/1ps
`include "sl28_defines.svh"

module sl28_cpld_top (
	input logic clk,
	input logic rst,
	input sl28_pkg::wb_req_t wb_req,
	output sl28_pkg::wb_rsp_t wb_rsp,
	input logic [`SL28_NUM_GPIO-1:0] gpio_in,
	output logic [`SL28_NUM_GPIO-1:0] gpio_out,
	output logic [`SL28_NUM_GPIO-1:0] gpio_oe,
	input logic pwr_btn_n,
	input logic sleep_n,
	input logic rtc_int_n,
	input logic smb_alert_n,
	output logic irq
);
	import sl28_pkg::*;

	csr_req_t csr;
	board_evt_t evt;
	logic gpio_irq;
	logic [`SL28_DATA_W-1:0] gpio_rdata;
	logic [`SL28_DATA_W-1:0] evt_rdata;
	logic [`SL28_DATA_W-1:0] intc_rdata;

	sl28_wb_csr sl28_wb_csr_i (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.csr(csr),
		.gpio_rdata(gpio_rdata),
		.evt_rdata(evt_rdata),
		.intc_rdata(intc_rdata)
	);

	sl28_gpio_bank sl28_gpio_bank_i (
		.clk(clk),
		.rst(rst),
		.csr(csr),
		.rdata(gpio_rdata),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.gpio_irq(gpio_irq)
	);

	sl28_event_inputs sl28_event_inputs_i (
		.clk(clk),
		.rst(rst),
		.csr(csr),
		.rdata(evt_rdata),
		.pwr_btn_n(pwr_btn_n),
		.sleep_n(sleep_n),
		.rtc_int_n(rtc_int_n),
		.smb_alert_n(smb_alert_n),
		.evt(evt)
	);

	sl28_intc sl28_intc_i (
		.clk(clk),
		.rst(rst),
		.csr(csr),
		.rdata(intc_rdata),
		.evt(evt),
		.gpio_irq(gpio_irq),
		.irq(irq)
	);

endmodule

// ==== verilog/sl28_defines.svh ====
// widths, register map, version and sizes of the bmc register file; include wherever they are used.
`ifndef SL28_DEFINES_SVH
`define SL28_DEFINES_SVH

// bus and register widths.
`define SL28_ADDR_W 5
`define SL28_DATA_W 8

`define SL28_NUM_GPIO 8
`define SL28_NUM_EVT 4
`define SL28_NUM_IRQ 5 // four board events plus gpio.

`define SL28_CPLD_VERSION 8'h1c

// register map.
`define SL28_ADDR_VERSION 5'h03
`define SL28_ADDR_GPIO_DIR 5'h10
`define SL28_ADDR_GPIO_OUT 5'h11
`define SL28_ADDR_GPIO_IN 5'h12
`define SL28_ADDR_GPIO_IE 5'h13
`define SL28_ADDR_GPIO_IP 5'h14
`define SL28_ADDR_GPI 5'h1b
`define SL28_ADDR_INTC_IE 5'h1c
`define SL28_ADDR_INTC_IP 5'h1d

`endif

// ==== verilog/sl28_event_inputs.sv ====
// board event inputs of the bmc; synchronizes the four signals, detects edges, serves the gpi register.
`timescale 1ns/1ps
`include "sl28_defines.svh"

module sl28_event_inputs (
	input logic clk,
	input logic rst,
	input sl28_pkg::csr_req_t csr,
	output logic [`SL28_DATA_W-1:0] rdata,
	input logic pwr_btn_n,
	input logic sleep_n,
	input logic rtc_int_n,
	input logic smb_alert_n,
	output sl28_pkg::board_evt_t evt
);
	logic [`SL28_NUM_EVT-1:0] pins;
	logic [`SL28_NUM_EVT-1:0] sync1;
	logic [`SL28_NUM_EVT-1:0] sync2;
	logic [`SL28_NUM_EVT-1:0] lvl_q;
	logic gpi_sel;

	// gpi bit order, high to low.
	assign pins = {smb_alert_n, rtc_int_n, sleep_n, pwr_btn_n};

	always_ff @(posedge clk) begin
		sync1 <= pins;
		sync2 <= sync1;
		lvl_q <= sync2; // last level, for the edge detect.
	end

	// one cycle pulses, all signals active low.
	always_comb begin
		evt.pwr_btn_edge = sync2[0] ^ lvl_q[0];
		evt.sleep_fall = lvl_q[1] & ~sync2[1];
		evt.rtc_fall = lvl_q[2] & ~sync2[2];
		evt.smb_alert_fall = lvl_q[3] & ~sync2[3];
	end

	// rst only holds the read path quiet.
	assign gpi_sel = csr.rd && !rst && csr.adr == `SL28_ADDR_GPI;

	always_comb begin
		rdata = '0;
		if (gpi_sel) begin
			rdata[`SL28_NUM_EVT-1:0] = lvl_q;
		end
	end

endmodule

// ==== verilog/sl28_gpio_bank.sv ====
// gpio bank of the bmc; direction, output and input-change interrupt registers for eight pins.
`timescale 1ns/1ps
`include "sl28_defines.svh"

module sl28_gpio_bank (
	input logic clk,
	input logic rst,
	input sl28_pkg::csr_req_t csr,
	output logic [`SL28_DATA_W-1:0] rdata,
	input logic [`SL28_NUM_GPIO-1:0] gpio_in,
	output logic [`SL28_NUM_GPIO-1:0] gpio_out,
	output logic [`SL28_NUM_GPIO-1:0] gpio_oe,
	output logic gpio_irq
);
	logic [`SL28_NUM_GPIO-1:0] dir_q;
	logic [`SL28_NUM_GPIO-1:0] out_q;
	logic [`SL28_NUM_GPIO-1:0] ie_q;
	logic [`SL28_NUM_GPIO-1:0] ip_q;
	logic [`SL28_NUM_GPIO-1:0] sync1;
	logic [`SL28_NUM_GPIO-1:0] sync2;
	logic [`SL28_NUM_GPIO-1:0] in_q;
	logic [`SL28_NUM_GPIO-1:0] chg;
	logic [`SL28_NUM_GPIO-1:0] ip_clr;

	// two stage synchronizer, then the edge flop.
	always_ff @(posedge clk) begin
		sync1 <= gpio_in;
		sync2 <= sync1;
		in_q <= sync2;
	end

	assign chg = sync2 ^ in_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			dir_q <= '0;
			out_q <= '0;
			ie_q <= '0;
		end else if (csr.wr) begin
			case (csr.adr)
				`SL28_ADDR_GPIO_DIR: dir_q <= csr.wdata;
				`SL28_ADDR_GPIO_OUT: out_q <= csr.wdata;
				`SL28_ADDR_GPIO_IE: ie_q <= csr.wdata;
				default: begin
				end
			endcase
		end
	end

	// write one to clear.
	assign ip_clr = (csr.wr && csr.adr == `SL28_ADDR_GPIO_IP) ? csr.wdata : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			ip_q <= '0;
		end else begin
			ip_q <= (ip_q & ~ip_clr) | chg; // a new change wins over the clear.
		end
	end

	always_comb begin
		rdata = '0;
		if (csr.rd) begin
			case (csr.adr)
				`SL28_ADDR_GPIO_DIR: rdata = dir_q;
				`SL28_ADDR_GPIO_OUT: rdata = out_q;
				`SL28_ADDR_GPIO_IN: rdata = in_q;
				`SL28_ADDR_GPIO_IE: rdata = ie_q;
				`SL28_ADDR_GPIO_IP: rdata = ip_q;
				default: rdata = '0;
			endcase
		end
	end

	assign gpio_out = out_q;
	assign gpio_oe = dir_q;
	assign gpio_irq = |(ip_q & ie_q); // level, registered in the intc.

endmodule

// ==== verilog/sl28_intc.sv ====
// interrupt controller of the bmc; latches board events, masks them, and drives the irq line.
`timescale 1ns/1ps
`include "sl28_defines.svh"

module sl28_intc (
	input logic clk,
	input logic rst,
	input sl28_pkg::csr_req_t csr,
	output logic [`SL28_DATA_W-1:0] rdata,
	input sl28_pkg::board_evt_t evt,
	input logic gpio_irq,
	output logic irq
);
	logic [`SL28_NUM_IRQ-1:0] ie_q;
	logic [`SL28_NUM_EVT-1:0] ip_q;
	logic [`SL28_NUM_EVT-1:0] evt_set;
	logic [`SL28_NUM_EVT-1:0] ip_clr;
	logic [`SL28_NUM_IRQ-1:0] src;

	// same order as the gpi register.
	assign evt_set = {evt.smb_alert_fall, evt.rtc_fall, evt.sleep_fall, evt.pwr_btn_edge};

	// gpio level sits on top, read only.
	assign src = {gpio_irq, ip_q};

	assign ip_clr = (csr.wr && csr.adr == `SL28_ADDR_INTC_IP) ?
		csr.wdata[`SL28_NUM_EVT-1:0] : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			ie_q <= '0;
		end else if (csr.wr && csr.adr == `SL28_ADDR_INTC_IE) begin
			ie_q <= csr.wdata[`SL28_NUM_IRQ-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ip_q <= '0;
		end else begin
			ip_q <= (ip_q & ~ip_clr) | evt_set; // set regardless of enable.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			irq <= 1'b0;
		end else begin
			irq <= |(src & ie_q);
		end
	end

	always_comb begin
		rdata = '0;
		if (csr.rd) begin
			case (csr.adr)
				`SL28_ADDR_INTC_IE: rdata[`SL28_NUM_IRQ-1:0] = ie_q;
				`SL28_ADDR_INTC_IP: rdata[`SL28_NUM_IRQ-1:0] = src;
				default: rdata = '0;
			endcase
		end
	end

endmodule

// ==== verilog/sl28_pkg.sv ====
// bus, register access and board event types shared by the bmc rtl and its testbench.
`include "sl28_defines.svh"

package sl28_pkg;

	// master to slave half of the wishbone bus.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`SL28_ADDR_W-1:0] adr;
		logic [`SL28_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [`SL28_DATA_W-1:0] dat;
	} wb_rsp_t;

	// one register access, strobes last a single cycle.
	typedef struct packed {
		logic wr;
		logic rd;
		logic [`SL28_ADDR_W-1:0] adr;
		logic [`SL28_DATA_W-1:0] wdata;
	} csr_req_t;

	typedef struct packed {
		logic pwr_btn_edge; // either edge.
		logic sleep_fall;
		logic rtc_fall;
		logic smb_alert_fall;
	} board_evt_t;

endpackage

// ==== verilog/sl28_wb_csr.sv ====
// wishbone classic slave of the bmc; turns bus cycles into register strobes and returns read data.
`timescale 1ns/1ps
`include "sl28_defines.svh"

module sl28_wb_csr (
	input logic clk,
	input logic rst,
	input sl28_pkg::wb_req_t wb_req,
	output sl28_pkg::wb_rsp_t wb_rsp,
	output sl28_pkg::csr_req_t csr,
	input logic [`SL28_DATA_W-1:0] gpio_rdata,
	input logic [`SL28_DATA_W-1:0] evt_rdata,
	input logic [`SL28_DATA_W-1:0] intc_rdata
);
	logic ack;
	logic access;
	logic [`SL28_DATA_W-1:0] version_rdata;
	logic [`SL28_DATA_W-1:0] rdata;
	logic [`SL28_DATA_W-1:0] rdata_q;

	assign access = wb_req.cyc & wb_req.stb & ~ack; // not yet acked.

	// strobes line up with the edge that raises ack.
	always_comb begin
		csr.wr = access & wb_req.we;
		csr.rd = access & ~wb_req.we;
		csr.adr = wb_req.adr;
		csr.wdata = wb_req.dat;
	end

	// version is read only, writes fall through.
	assign version_rdata = (csr.rd && csr.adr == `SL28_ADDR_VERSION) ?
		`SL28_CPLD_VERSION : '0;

	// blocks drive zero unless they own the address.
	assign rdata = version_rdata | gpio_rdata | evt_rdata | intc_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rdata_q <= rdata; // valid while ack is high.
		end
	end

	always_comb begin
		wb_rsp.ack = ack;
		wb_rsp.dat = rdata_q;
	end

endmodule
